/* flist.f */
design/com_pkg.sv
design/wb_pkg.sv
design/com_fifo.sv
design/req_dispatch.sv
design/slave_port.sv
design/resp_merge.sv
design/wb_commutator.sv
testbench/wb_slave_model.sv
testbench/wb_commutator_chk.sv
testbench/tb_wb_commutator.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_wb_commutator -f flist.f

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/Vtb_wb_commutator +verilator+error+limit+1000 | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* testbench/tb_wb_commutator.sv */
`timescale 1ns/1ps

module tb_wb_commutator;

  localparam int          NUM_SLAVES = 2;
  localparam int          FIFO_ASIZE = 2;
  localparam logic [31:0] SEED       = 32'h4c76_4ad1;

  logic                                   clk;
  logic                                   rst;
  logic [1:0]                             req_valid;
  com_pkg::com_req_t [1:0]                req;
  logic [1:0]                             req_ready;
  logic [1:0]                             rsp_valid;
  com_pkg::com_rsp_t [1:0]                rsp;
  logic [1:0]                             rsp_ready;
  wire wb_pkg::wb_m2s_t [NUM_SLAVES-1:0]  m2s;
  wire wb_pkg::wb_s2m_t [NUM_SLAVES-1:0]  s2m;

  logic [31:0]    rnd_state = SEED;
  logic [1:0]     blocked;
  com_pkg::data_t shadow [com_pkg::addr_t];
  com_pkg::data_t exp_q [2][$];
  int             err_cnt = 0;
  int             to_cnt = 0;
  int             rsp_cnt = 0;

  wb_commutator #(.NUM_SLAVES(NUM_SLAVES), .FIFO_ASIZE(FIFO_ASIZE)) dut0 (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .wb_m2s_o    (m2s),
    .wb_s2m_i    (s2m)
  );

  // Slave 1 acks much later than slave 0
  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
    wb_slave_model #(.SEED(SEED ^ (32'h0101_0101 * 32'(s + 1))), .MAX_LAT(1 + 3 * s)) u_slv (
      .clk      (clk),
      .rst      (rst),
      .wb_m2s_i (m2s[s]),
      .wb_s2m_o (s2m[s])
    );
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic com_pkg::data_t preset_word(com_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h6b3d_91e5;
  endfunction

  function automatic com_pkg::data_t merge_bytes(com_pkg::data_t old, com_pkg::data_t wr,
                                                 com_pkg::sel_t sel);
    com_pkg::data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wr[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic bit traffic_done();
    return req_valid == 2'b00 && exp_q[0].size() == 0 && exp_q[1].size() == 0;
  endfunction

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  // Address bit 5 keeps the two masters on separate words
  task automatic new_request(input int m);
    logic [31:0] r;
    rnd_state = next_random(rnd_state);
    r = rnd_state;
    rnd_state = next_random(rnd_state);
    req[m].addr = {r[0], 25'h0, m[0], r[3:1], 2'b00};
    req[m].data = rnd_state;
    req[m].sel  = r[7:4];
    req[m].we   = r[8];
    req_valid[m] = 1'b1;
  endtask

  // rdy_mode 0 holds responses, 1 takes them, 2 is random
  task automatic step(input bit new_req, input int rdy_mode);
    logic [1:0] fired;
    @(posedge clk);
    fired = req_valid & req_ready;
    blocked = blocked | (req_valid & ~req_ready);
    #10;
    for (int m = 0; m < 2; m++) begin
      if (fired[m]) begin
        req_valid[m] = 1'b0;
      end
      rnd_state = next_random(rnd_state);
      if (new_req && !req_valid[m] && rnd_state[1:0] != 2'b00) begin
        new_request(m);
      end
      if (rdy_mode == 0) begin
        rsp_ready[m] = 1'b0;
      end else if (rdy_mode == 1) begin
        rsp_ready[m] = 1'b1;
      end else begin
        rsp_ready[m] = rnd_state[4:2] != 3'b000;
      end
    end
  endtask

  task automatic drain(input int limit);
    for (int t = 0; t < limit && !traffic_done(); t++) begin
      step(1'b0, 1);
    end
    if (!traffic_done()) begin
      to_cnt++;
      $display("Timeout while draining, responses still outstanding");
    end
  endtask

  // ----------------------------------------------------------
  // Expected responses from the shadow memory
  // ----------------------------------------------------------
  always @(posedge clk) begin
    com_pkg::data_t word;
    com_pkg::data_t exp;
    if (!rst) begin
      for (int m = 0; m < 2; m++) begin
        if (req_valid[m] && req_ready[m]) begin
          word = shadow.exists(req[m].addr) ? shadow[req[m].addr] : preset_word(req[m].addr);
          if (req[m].we) begin
            word = merge_bytes(word, req[m].data, req[m].sel);
            shadow[req[m].addr] = word;
          end
          exp_q[m].push_back(word);
        end
        if (rsp_valid[m] && rsp_ready[m]) begin
          assert (exp_q[m].size() != 0) else begin
            err_cnt++;
            $display("Master %0d got a response with no request outstanding", m);
          end
          if (exp_q[m].size() != 0) begin
            exp = exp_q[m].pop_front();
            rsp_cnt++;
            assert (rsp[m].data == exp) else begin
              err_cnt++;
              $display("ERROR rsp_o[%0d].data = %h, expected %h", m, rsp[m].data, exp);
            end
          end
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    req_valid = 2'b00;
    req = '0;
    rsp_ready = 2'b00;
    blocked = 2'b00;
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;

    // Mixed traffic on both slaves
    for (int i = 0; i < 600; i++) begin
      step(1'b1, 2);
    end

    // Hold all responses until both masters are refused
    blocked = 2'b00;
    for (int t = 0; t < 300 && blocked != 2'b11; t++) begin
      step(1'b1, 0);
    end
    if (blocked != 2'b11) begin
      to_cnt++;
      $display("Timeout, req_ready_o never dropped while responses were held");
    end
    for (int i = 0; i < 20; i++) begin
      step(1'b0, 0);
    end

    drain(3000);
    repeat (2) @(posedge clk);

    $display("Responses %0d, data errors %0d, timeouts %0d, assertion errors %0d",
             rsp_cnt, err_cnt, to_cnt, dut0.u_chk.fail_cnt);
    if (err_cnt == 0 && to_cnt == 0 && dut0.u_chk.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* testbench/wb_commutator_chk.sv */
`timescale 1ns/1ps

module wb_commutator_chk #(
  parameter int NUM_SLAVES = 2
) (
  input logic                             clk,
  input logic                             rst,
  input logic [1:0]                       req_valid_i,
  input com_pkg::com_req_t [1:0]          req_i,
  input logic [1:0]                       req_ready_i,
  input logic [1:0]                       rsp_valid_i,
  input com_pkg::com_rsp_t [1:0]          rsp_i,
  input logic [1:0]                       rsp_ready_i,
  input wb_pkg::wb_m2s_t [NUM_SLAVES-1:0] m2s_i,
  input wb_pkg::wb_s2m_t [NUM_SLAVES-1:0] s2m_i
);

  localparam int SW = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

  int                          fail_cnt = 0;
  logic [NUM_SLAVES-1:0][7:0]  open_cnt;
  logic [1:0]                  acc;
  int unsigned                 seq_cnt;

  assign acc = req_valid_i & req_ready_i;

  // Dispatch order number, master 0 first on a shared cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else begin
      seq_cnt <= seq_cnt + 32'(acc[0]) + 32'(acc[1]);
    end
  end

  // ----------------------------------------------------------
  // Wishbone side, one set per slave
  // ----------------------------------------------------------
  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
    logic           iss;
    logic           exp_vld;
    logic           exp_mst;
    com_pkg::addr_t exp_adr;
    com_pkg::addr_t adr_q [2][$];
    int unsigned    seq_q [2][$];

    assign iss = m2s_i[s].cyc && m2s_i[s].stb && !s2m_i[s].stall;

    always_ff @(posedge clk) begin
      if (rst) begin
        open_cnt[s] <= '0;
      end else begin
        open_cnt[s] <= open_cnt[s] + {7'd0, iss} - {7'd0, s2m_i[s].ack};
      end
    end

    // Requests waiting for this slave, per master in dispatch order
    always @(posedge clk) begin
      int tgt;
      int pk;
      if (rst) begin
        for (int m = 0; m < 2; m++) begin
          adr_q[m].delete();
          seq_q[m].delete();
        end
        exp_vld <= 1'b0;
        exp_mst <= 1'b0;
        exp_adr <= '0;
      end else begin
        if (iss && exp_vld) begin
          void'(adr_q[exp_mst].pop_front());
          void'(seq_q[exp_mst].pop_front());
        end
        for (int m = 0; m < 2; m++) begin
          tgt = (NUM_SLAVES > 1) ? int'(req_i[m].addr[31 -: SW]) : 0;
          if (acc[m] && tgt == s) begin
            adr_q[m].push_back(req_i[m].addr);
            seq_q[m].push_back(seq_cnt + 32'(m == 1 && acc[0]));
          end
        end
        // First dispatched pending request goes out next
        pk = (adr_q[0].size() == 0 ||
              (adr_q[1].size() != 0 && seq_q[1][0] < seq_q[0][0])) ? 1 : 0;
        exp_vld <= adr_q[pk].size() != 0;
        exp_mst <= pk[0];
        exp_adr <= (adr_q[pk].size() != 0) ? adr_q[pk][0] : '0;
      end
    end

    a_rst_bus: assert property (@(posedge clk) rst |=> !m2s_i[s].cyc && !m2s_i[s].stb)
      else begin fail_cnt++; $error("Bus active right after reset"); end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst) m2s_i[s].stb |-> m2s_i[s].cyc)
      else begin fail_cnt++; $error("stb without cyc"); end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      m2s_i[s].stb && s2m_i[s].stall |=> m2s_i[s].stb &&
      $stable({m2s_i[s].adr, m2s_i[s].dat, m2s_i[s].sel, m2s_i[s].we}))
      else begin fail_cnt++; $error("Request changed under stall"); end

    a_ack_bound: assert property (@(posedge clk) disable iff (rst)
      s2m_i[s].ack |-> open_cnt[s] != 8'd0)
      else begin fail_cnt++; $error("Ack with no request outstanding"); end

    a_oldest: assert property (@(posedge clk) disable iff (rst)
      m2s_i[s].stb |-> exp_vld && m2s_i[s].adr == exp_adr)
      else begin fail_cnt++; $error("Issued request is not the oldest pending one"); end
  end

  // Master side
  for (genvar m = 0; m < 2; m++) begin : g_mst
    a_rst_rsp: assert property (@(posedge clk) rst |=> !rsp_valid_i[m])
      else begin fail_cnt++; $error("Response valid right after reset"); end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid_i[m] && !rsp_ready_i[m] |=> rsp_valid_i[m] && $stable(rsp_i[m]))
      else begin fail_cnt++; $error("Response dropped or changed while not taken"); end
  end

endmodule

bind wb_commutator wb_commutator_chk #(.NUM_SLAVES(NUM_SLAVES)) u_chk (
  .clk         (clk),
  .rst         (rst),
  .req_valid_i (req_valid_i),
  .req_i       (req_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_i       (rsp_o),
  .rsp_ready_i (rsp_ready_i),
  .m2s_i       (wb_m2s_o),
  .s2m_i       (wb_s2m_i)
);

/* testbench/wb_slave_model.sv */
`timescale 1ns/1ps

module wb_slave_model #(
  parameter logic [31:0] SEED    = 32'h4c76_4ad1,
  parameter int          MAX_LAT = 3
) (
  input  logic            clk,
  input  logic            rst,
  input  wb_pkg::wb_m2s_t wb_m2s_i,
  output wb_pkg::wb_s2m_t wb_s2m_o
);

  com_pkg::data_t mem [com_pkg::addr_t];
  com_pkg::data_t ack_dat_q [$];
  int             ack_due_q [$];
  int             cycle;
  logic [31:0]    rnd;
  logic           stall_q;
  logic           ack_q;
  com_pkg::data_t dat_q;

  function automatic logic [31:0] shift_rand(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Contents of a word never written
  function automatic com_pkg::data_t init_word(com_pkg::addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h6b3d_91e5;
  endfunction

  assign wb_s2m_o.dat   = dat_q;
  assign wb_s2m_o.ack   = ack_q;
  assign wb_s2m_o.stall = stall_q;

  always @(posedge clk) begin
    com_pkg::data_t word;
    int             lat;
    if (rst) begin
      rnd = SEED;
      cycle = 0;
      ack_dat_q.delete();
      ack_due_q.delete();
      stall_q <= 1'b0;
      ack_q   <= 1'b0;
      dat_q   <= '0;
    end else begin
      rnd = shift_rand(rnd);
      // Access takes effect at issue, ack follows after a random delay
      if (wb_m2s_i.cyc && wb_m2s_i.stb && !stall_q) begin
        word = mem.exists(wb_m2s_i.adr) ? mem[wb_m2s_i.adr] : init_word(wb_m2s_i.adr);
        if (wb_m2s_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_m2s_i.sel[b]) begin
              word[8*b +: 8] = wb_m2s_i.dat[8*b +: 8];
            end
          end
          mem[wb_m2s_i.adr] = word;
        end
        lat = 1 + int'(rnd[7:0]) % MAX_LAT;
        ack_dat_q.push_back(word);
        ack_due_q.push_back(cycle + lat);
      end
      // Acks leave strictly in issue order
      ack_q <= 1'b0;
      if (ack_due_q.size() != 0 && ack_due_q[0] <= cycle) begin
        ack_q <= 1'b1;
        dat_q <= ack_dat_q.pop_front();
        void'(ack_due_q.pop_front());
      end
      stall_q <= rnd[31:30] == 2'b00;
      cycle = cycle + 1;
    end
  end

endmodule

/* design/wb_commutator.sv */
`timescale 1ns/1ps

module wb_commutator #(
  parameter int NUM_SLAVES = 2,
  parameter int FIFO_ASIZE = 2,
  localparam int SW = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [1:0]                           req_valid_i,
  input  com_pkg::com_req_t [1:0]              req_i,
  output logic [1:0]                           req_ready_o,
  output logic [1:0]                           rsp_valid_o,
  output com_pkg::com_rsp_t [1:0]              rsp_o,
  input  logic [1:0]                           rsp_ready_i,
  output wire wb_pkg::wb_m2s_t [NUM_SLAVES-1:0] wb_m2s_o,
  input  wb_pkg::wb_s2m_t [NUM_SLAVES-1:0]     wb_s2m_i
);

  wire com_pkg::com_hdr_t [1:0][NUM_SLAVES-1:0] hdr;
  wire [1:0][NUM_SLAVES-1:0]                    hdr_empty;
  wire [1:0][NUM_SLAVES-1:0]                    hdr_pop;
  wire [1:0][SW-1:0]                            ord;
  wire [1:0]                                    ord_empty;
  wire [1:0]                                    ord_pop;
  wire com_pkg::com_rsp_t [1:0][NUM_SLAVES-1:0] rsp;
  wire [1:0][NUM_SLAVES-1:0]                    rsp_empty;
  wire [1:0][NUM_SLAVES-1:0]                    rsp_pop;

  req_dispatch #(.NUM_SLAVES(NUM_SLAVES), .FIFO_ASIZE(FIFO_ASIZE)) u_dispatch (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .hdr_o       (hdr),
    .hdr_empty_o (hdr_empty),
    .hdr_pop_i   (hdr_pop),
    .ord_o       (ord),
    .ord_empty_o (ord_empty),
    .ord_pop_i   (ord_pop)
  );

  // ----------------------------------------------------------
  // One port per slave
  // ----------------------------------------------------------
  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_port
    slave_port #(.FIFO_ASIZE(FIFO_ASIZE)) u_port (
      .clk          (clk),
      .rst          (rst),
      .hdr0_i       (hdr[0][s]),
      .hdr0_empty_i (hdr_empty[0][s]),
      .hdr0_pop_o   (hdr_pop[0][s]),
      .hdr1_i       (hdr[1][s]),
      .hdr1_empty_i (hdr_empty[1][s]),
      .hdr1_pop_o   (hdr_pop[1][s]),
      .wb_m2s_o     (wb_m2s_o[s]),
      .wb_s2m_i     (wb_s2m_i[s]),
      .rsp0_o       (rsp[0][s]),
      .rsp0_empty_o (rsp_empty[0][s]),
      .rsp0_pop_i   (rsp_pop[0][s]),
      .rsp1_o       (rsp[1][s]),
      .rsp1_empty_o (rsp_empty[1][s]),
      .rsp1_pop_i   (rsp_pop[1][s])
    );
  end

  resp_merge #(.NUM_SLAVES(NUM_SLAVES)) u_merge (
    .clk         (clk),
    .rst         (rst),
    .ord_i       (ord),
    .ord_empty_i (ord_empty),
    .ord_pop_o   (ord_pop),
    .rsp_i       (rsp),
    .rsp_empty_i (rsp_empty),
    .rsp_pop_o   (rsp_pop),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

/* design/resp_merge.sv */
`timescale 1ns/1ps

module resp_merge #(
  parameter int NUM_SLAVES = 2,
  localparam int SW = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [1:0][SW-1:0]                      ord_i,
  input  logic [1:0]                              ord_empty_i,
  output logic [1:0]                              ord_pop_o,
  input  com_pkg::com_rsp_t [1:0][NUM_SLAVES-1:0] rsp_i,
  input  logic [1:0][NUM_SLAVES-1:0]              rsp_empty_i,
  output logic [1:0][NUM_SLAVES-1:0]              rsp_pop_o,
  output logic [1:0]                              rsp_valid_o,
  output com_pkg::com_rsp_t [1:0]                 rsp_o,
  input  logic [1:0]                              rsp_ready_i
);

  typedef enum logic {
    MRG_IDLE,
    MRG_HOLD
  } mrg_state_e;

  mrg_state_e [1:0] state_q;
  logic [1:0]       avail;
  logic [1:0]       load;

  // Order queue head names the slave holding the next response
  always_comb begin
    rsp_pop_o = '0;
    for (int m = 0; m < 2; m++) begin
      avail[m] = !ord_empty_i[m] && !rsp_empty_i[m][ord_i[m]];
      // Reload in the same cycle the held response is taken
      load[m]  = avail[m] && (state_q[m] == MRG_IDLE || rsp_ready_i[m]);
      ord_pop_o[m]           = load[m];
      rsp_pop_o[m][ord_i[m]] = load[m];
      rsp_valid_o[m]         = state_q[m] == MRG_HOLD;
    end
  end

  always_ff @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (rst) begin
        state_q[m] <= MRG_IDLE;
      end else if (load[m]) begin
        state_q[m] <= MRG_HOLD;
      end else if (rsp_ready_i[m]) begin
        state_q[m] <= MRG_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (load[m]) begin
        rsp_o[m] <= rsp_i[m][ord_i[m]];
      end
    end
  end

endmodule

/* design/slave_port.sv */
`timescale 1ns/1ps

module slave_port #(
  parameter int FIFO_ASIZE = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  com_pkg::com_hdr_t hdr0_i,
  input  logic              hdr0_empty_i,
  output logic              hdr0_pop_o,
  input  com_pkg::com_hdr_t hdr1_i,
  input  logic              hdr1_empty_i,
  output logic              hdr1_pop_o,
  output wb_pkg::wb_m2s_t   wb_m2s_o,
  input  wb_pkg::wb_s2m_t   wb_s2m_i,
  output com_pkg::com_rsp_t rsp0_o,
  output logic              rsp0_empty_o,
  input  logic              rsp0_pop_i,
  output com_pkg::com_rsp_t rsp1_o,
  output logic              rsp1_empty_o,
  input  logic              rsp1_pop_i
);

  localparam int DEPTH = 1 << FIFO_ASIZE;

  com_pkg::com_hdr_t             head;
  logic                          pick1;
  logic                          pending;
  logic                          stb;
  logic                          issue;
  logic                          ack;
  logic [1:0]                    credit_ok;
  logic [1:0]                    mst_inc;
  logic [1:0]                    mst_dec;
  logic [1:0][FIFO_ASIZE:0]      mst_out;
  wire [1:0][FIFO_ASIZE:0]       rsp_count;
  wire [1:0]                     rsp_empty;
  wire com_pkg::com_rsp_t [1:0]  rsp_data;
  logic [DEPTH-1:0]              dir_q;
  logic [DEPTH-1:0]              dir_nxt;
  logic [FIFO_ASIZE:0]           out_cnt;
  logic [FIFO_ASIZE:0]           cnt_nxt;
  logic                          ack_q;
  logic                          ack_dir_q;
  com_pkg::com_rsp_t             ack_rsp_q;

  // ----------------------------------------------------------
  // Oldest-first selection and bus issue
  // ----------------------------------------------------------
  assign pick1 = hdr0_empty_i ||
                 (!hdr1_empty_i && com_pkg::tag_older(hdr1_i.tag, hdr0_i.tag));
  assign head    = pick1 ? hdr1_i : hdr0_i;
  assign pending = pick1 ? !hdr1_empty_i : !hdr0_empty_i;

  // Outstanding plus queued responses must stay below queue depth
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      credit_ok[m] = ({1'b0, mst_out[m]} + {1'b0, rsp_count[m]}) < DEPTH;
    end
  end

  assign stb   = pending && credit_ok[pick1] && (out_cnt < DEPTH);
  assign issue = stb && !wb_s2m_i.stall;
  assign ack   = wb_s2m_i.ack && (out_cnt != '0);

  assign hdr0_pop_o = issue && !pick1;
  assign hdr1_pop_o = issue && pick1;

  always_comb begin
    wb_m2s_o.adr = head.req.addr;
    wb_m2s_o.dat = head.req.data;
    wb_m2s_o.sel = head.req.sel;
    wb_m2s_o.we  = head.req.we;
    wb_m2s_o.stb = stb;
    wb_m2s_o.cyc = stb || (out_cnt != '0);
  end

  // ----------------------------------------------------------
  // Owner of each outstanding request, oldest at bit 0
  // ----------------------------------------------------------
  always_comb begin
    dir_nxt = dir_q;
    cnt_nxt = out_cnt;
    if (ack) begin
      dir_nxt = dir_q >> 1;
      cnt_nxt = out_cnt - 1'b1;
    end
    if (issue) begin
      dir_nxt[cnt_nxt[FIFO_ASIZE-1:0]] = pick1;
      cnt_nxt = cnt_nxt + 1'b1;
    end
  end

  assign mst_inc = {issue && pick1, issue && !pick1};
  assign mst_dec = {ack_q && ack_dir_q, ack_q && !ack_dir_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      dir_q     <= '0;
      out_cnt   <= '0;
      ack_q     <= 1'b0;
      ack_dir_q <= 1'b0;
      mst_out   <= '0;
    end else begin
      dir_q     <= dir_nxt;
      out_cnt   <= cnt_nxt;
      ack_q     <= ack;
      ack_dir_q <= dir_q[0];
      for (int m = 0; m < 2; m++) begin
        if (mst_inc[m] && !mst_dec[m]) begin
          mst_out[m] <= mst_out[m] + 1'b1;
        end else if (mst_dec[m] && !mst_inc[m]) begin
          mst_out[m] <= mst_out[m] - 1'b1;
        end
      end
    end
  end

  // Ack data lands in the owner's queue one cycle later
  always_ff @(posedge clk) begin
    ack_rsp_q.data <= wb_s2m_i.dat;
  end

  for (genvar m = 0; m < 2; m++) begin : g_rsp
    com_fifo #(.WIDTH($bits(com_pkg::com_rsp_t)), .ASIZE(FIFO_ASIZE)) u_rsp (
      .clk       (clk),
      .rst       (rst),
      .wr_en_i   (mst_dec[m]),
      .wr_data_i (ack_rsp_q),
      .rd_en_i   ((m == 0) ? rsp0_pop_i : rsp1_pop_i),
      .rd_data_o (rsp_data[m]),
      .full_o    (),
      .empty_o   (rsp_empty[m]),
      .count_o   (rsp_count[m])
    );
  end

  assign rsp0_o       = rsp_data[0];
  assign rsp1_o       = rsp_data[1];
  assign rsp0_empty_o = rsp_empty[0];
  assign rsp1_empty_o = rsp_empty[1];

endmodule

/* design/req_dispatch.sv */
`timescale 1ns/1ps

module req_dispatch #(
  parameter int NUM_SLAVES = 2,
  parameter int FIFO_ASIZE = 2,
  localparam int SW = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [1:0]                                   req_valid_i,
  input  com_pkg::com_req_t [1:0]                      req_i,
  output logic [1:0]                                   req_ready_o,
  output wire com_pkg::com_hdr_t [1:0][NUM_SLAVES-1:0] hdr_o,
  output wire [1:0][NUM_SLAVES-1:0]                    hdr_empty_o,
  input  logic [1:0][NUM_SLAVES-1:0]                   hdr_pop_i,
  output wire [1:0][SW-1:0]                            ord_o,
  output wire [1:0]                                    ord_empty_o,
  input  logic [1:0]                                   ord_pop_i
);

  localparam int AMSB = $bits(com_pkg::addr_t) - 1;

  logic [1:0][SW-1:0]        tgt;
  logic [1:0]                acc;
  com_pkg::tag_t             tag_cnt;
  com_pkg::tag_t [1:0]       tag;
  com_pkg::com_hdr_t [1:0]   hdr_in;
  wire [1:0][NUM_SLAVES-1:0] hdr_full;
  wire [1:0]                 ord_full;

  // ----------------------------------------------------------
  // Decode, room check and tag stamping
  // ----------------------------------------------------------
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      if (NUM_SLAVES > 1) begin
        tgt[m] = req_i[m].addr[AMSB -: SW];
      end else begin
        tgt[m] = '0;
      end
      req_ready_o[m] = !hdr_full[m][tgt[m]] && !ord_full[m];
      acc[m]         = req_valid_i[m] && req_ready_o[m];
    end
    // Master 0 takes the lower tag on a shared cycle
    tag[0] = tag_cnt;
    tag[1] = tag_cnt + com_pkg::tag_t'(acc[0]);
    for (int m = 0; m < 2; m++) begin
      hdr_in[m].req = req_i[m];
      hdr_in[m].tag = tag[m];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_cnt <= '0;
    end else begin
      tag_cnt <= tag_cnt + com_pkg::tag_t'(acc[0]) + com_pkg::tag_t'(acc[1]);
    end
  end

  // ----------------------------------------------------------
  // Order queue per master, request queue per master and slave
  // ----------------------------------------------------------
  for (genvar m = 0; m < 2; m++) begin : g_mst
    com_fifo #(.WIDTH(SW), .ASIZE(FIFO_ASIZE)) u_ord (
      .clk       (clk),
      .rst       (rst),
      .wr_en_i   (acc[m]),
      .wr_data_i (tgt[m]),
      .rd_en_i   (ord_pop_i[m]),
      .rd_data_o (ord_o[m]),
      .full_o    (ord_full[m]),
      .empty_o   (ord_empty_o[m]),
      .count_o   ()
    );

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
      com_fifo #(.WIDTH($bits(com_pkg::com_hdr_t)), .ASIZE(FIFO_ASIZE)) u_req (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (acc[m] && (tgt[m] == SW'(s))),
        .wr_data_i (hdr_in[m]),
        .rd_en_i   (hdr_pop_i[m][s]),
        .rd_data_o (hdr_o[m][s]),
        .full_o    (hdr_full[m][s]),
        .empty_o   (hdr_empty_o[m][s]),
        .count_o   ()
      );
    end
  end

endmodule

/* design/com_fifo.sv */
`timescale 1ns/1ps

module com_fifo #(
  parameter int WIDTH = 32,
  parameter int ASIZE = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] wr_data_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] rd_data_o,
  output logic             full_o,
  output logic             empty_o,
  output logic [ASIZE:0]   count_o
);

  localparam int DEPTH = 1 << ASIZE;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [ASIZE-1:0] wr_ptr;
  logic [ASIZE-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign full_o  = count_o == (ASIZE+1)'(DEPTH);
  assign empty_o = count_o == '0;
  assign do_wr   = wr_en_i && !full_o;
  assign do_rd   = rd_en_i && !empty_o;

  // Head word is visible without a read strobe
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count_o <= count_o + 1'b1;
      end else if (do_rd && !do_wr) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

endmodule

/* design/wb_pkg.sv */
package wb_pkg;

  // Bus vectors share the commutator widths
  typedef com_pkg::addr_t wb_adr_t;
  typedef com_pkg::data_t wb_dat_t;
  typedef com_pkg::sel_t  wb_sel_t;

  typedef struct packed {
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
    logic    we;
    logic    cyc;
    logic    stb;
  } wb_m2s_t;

  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
    logic    stall;
  } wb_s2m_t;

endpackage

/* design/com_pkg.sv */
package com_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  // Phase bit on top, wrapping issue count below
  typedef logic [3:0]  tag_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    sel_t  sel;
    logic  we;
  } com_req_t;

  // Request as queued toward a slave port
  typedef struct packed {
    com_req_t req;
    tag_t     tag;
  } com_hdr_t;

  typedef struct packed {
    data_t data;
  } com_rsp_t;

  // True when tag a was issued before tag b
  function automatic logic tag_older(tag_t a, tag_t b);
    if (a[3] != b[3]) begin
      return a[2:0] > b[2:0];
    end
    return a[2:0] < b[2:0];
  endfunction

endpackage
